/* src/simt_pkg.sv */
`default_nettype none

package simt_pkg;

	parameter int NUM_THREADS    = 4;
	parameter int RESULT_CREDITS = 4; // slots granted by the consumer
	parameter int XLEN           = 32;

	typedef logic [4:0]      reg_idx_t;
	typedef logic [XLEN-1:0] word_t;

	typedef enum logic [3:0] {
		OP_NONE = 4'd0, // bubble
		OP_ADD  = 4'd1,
		OP_SUB  = 4'd2,
		OP_AND  = 4'd3,
		OP_OR   = 4'd4,
		OP_XOR  = 4'd5,
		OP_SLL  = 4'd6,
		OP_SRL  = 4'd7,
		OP_SLT  = 4'd8,
		OP_LUI  = 4'd9
	} alu_op_e;

	typedef struct packed {
		alu_op_e  alu_op;
		reg_idx_t rd;
		reg_idx_t rs1;
		reg_idx_t rs2;
		logic     use_imm; // operand b is imm
		word_t    imm;     // I-type sign extended, or U-type
		logic     wb;      // writes rd
	} decoded_t;

	typedef struct packed {
		decoded_t                  dec;
		word_t [NUM_THREADS-1:0]   a;
		word_t [NUM_THREADS-1:0]   b;
		logic  [NUM_THREADS-1:0]   mask;
	} de_bundle_t;

	typedef struct packed {
		reg_idx_t                  rd;
		word_t [NUM_THREADS-1:0]   data;
		logic  [NUM_THREADS-1:0]   mask;
	} result_t;

endpackage

`default_nettype wire

/* src/inst_decoder.sv */
`timescale 1ns/1ps
`default_nettype none

module inst_decoder (
	input  simt_pkg::word_t    instr,
	output simt_pkg::decoded_t decoded
);
	import simt_pkg::*;

	localparam logic [6:0] OPC_OP     = 7'b0110011;
	localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
	localparam logic [6:0] OPC_LUI    = 7'b0110111;
	localparam logic [6:0] F7_BASE    = 7'b0000000;
	localparam logic [6:0] F7_ALT     = 7'b0100000;

	logic [6:0] opcode;
	logic [2:0] funct3;
	logic [6:0] funct7;
	word_t      imm_i;
	word_t      imm_u;
	alu_op_e    op;

	assign opcode = instr[6:0];
	assign funct3 = instr[14:12];
	assign funct7 = instr[31:25];
	assign imm_i  = {{(XLEN-12){instr[31]}}, instr[31:20]};
	assign imm_u  = {instr[31:12], 12'b0};

	always_comb begin
		op = OP_NONE;
		case (opcode)
			OPC_OP: begin
				case (funct3)
					3'b000: begin
						if (funct7 == F7_BASE)
							op = OP_ADD;
						else if (funct7 == F7_ALT)
							op = OP_SUB;
					end
					3'b001: if (funct7 == F7_BASE) op = OP_SLL;
					3'b010: if (funct7 == F7_BASE) op = OP_SLT;
					3'b100: if (funct7 == F7_BASE) op = OP_XOR;
					3'b101: if (funct7 == F7_BASE) op = OP_SRL; // no SRA
					3'b110: if (funct7 == F7_BASE) op = OP_OR;
					3'b111: if (funct7 == F7_BASE) op = OP_AND;
					default: op = OP_NONE; // SLTU
				endcase
			end
			OPC_OP_IMM: begin
				case (funct3)
					3'b000: op = OP_ADD;
					3'b001: if (funct7 == F7_BASE) op = OP_SLL;
					3'b010: op = OP_SLT;
					3'b100: op = OP_XOR;
					3'b101: if (funct7 == F7_BASE) op = OP_SRL; // SRAI dropped
					3'b110: op = OP_OR;
					3'b111: op = OP_AND;
					default: op = OP_NONE;
				endcase
			end
			OPC_LUI: op = OP_LUI;
			default: op = OP_NONE;
		endcase
	end

	// unused source fields stay x0 so they never raise a hazard
	always_comb begin
		decoded = '0;
		if (op != OP_NONE) begin
			decoded.alu_op  = op;
			decoded.rd      = instr[11:7];
			decoded.wb      = 1'b1;
			decoded.use_imm = (opcode != OPC_OP);
			decoded.rs1     = (opcode == OPC_LUI) ? reg_idx_t'(0) : instr[19:15];
			decoded.rs2     = (opcode == OPC_OP) ? instr[24:20] : reg_idx_t'(0);
			decoded.imm     = (opcode == OPC_LUI) ? imm_u : imm_i;
		end
	end

endmodule

`default_nettype wire

/* src/thread_regfile.sv */
`timescale 1ns/1ps
`default_nettype none

module thread_regfile #(
	parameter int NUM_THREADS = simt_pkg::NUM_THREADS
) (
	input  logic                                 clk,
	input  logic                                 reset,
	input  simt_pkg::reg_idx_t                   rs1,
	input  simt_pkg::reg_idx_t                   rs2,
	output simt_pkg::word_t [NUM_THREADS-1:0]    rd_a,
	output simt_pkg::word_t [NUM_THREADS-1:0]    rd_b,
	input  logic [NUM_THREADS-1:0]               wr_en,
	input  simt_pkg::reg_idx_t                   wr_idx,
	input  simt_pkg::word_t [NUM_THREADS-1:0]    wr_data
);
	import simt_pkg::*;

	word_t regs [NUM_THREADS][32];

	always_ff @(posedge clk) begin
		if (reset) begin
			for (int t = 0; t < NUM_THREADS; t++) begin
				for (int r = 0; r < 32; r++) begin
					regs[t][r] <= '0;
				end
			end
		end else begin
			for (int t = 0; t < NUM_THREADS; t++) begin
				if (wr_en[t] && wr_idx != '0) // x0 never written
					regs[t][wr_idx] <= wr_data[t];
			end
		end
	end

	// a write in flight is visible to the reader in the same cycle
	always_comb begin
		for (int t = 0; t < NUM_THREADS; t++) begin
			rd_a[t] = regs[t][rs1];
			rd_b[t] = regs[t][rs2];
			if (wr_en[t] && wr_idx != '0) begin
				if (wr_idx == rs1)
					rd_a[t] = wr_data[t];
				if (wr_idx == rs2)
					rd_b[t] = wr_data[t];
			end
		end
	end

	a_x0_zero: assert property (@(posedge clk) disable iff (reset)
		(rs1 != '0 || rd_a == '0) && (rs2 != '0 || rd_b == '0));

endmodule

`default_nettype wire

/* src/d_e_reg.sv */
`timescale 1ns/1ps
`default_nettype none

module d_e_reg #(
	parameter int NUM_THREADS = simt_pkg::NUM_THREADS
) (
	input  logic                 clk,
	input  logic                 reset,
	input  logic                 stall,
	input  logic                 freeze,
	input  logic                 load,
	input  simt_pkg::de_bundle_t in_bundle,
	output simt_pkg::de_bundle_t out_bundle
);
	import simt_pkg::*;

	// all-zero is OP_NONE, no writeback and no active threads
	localparam de_bundle_t BUBBLE = '0;

	logic advance;

	// unsupported encodings are squashed here with their mask
	assign advance = load && !stall && (in_bundle.dec.alu_op != OP_NONE);

	always_ff @(posedge clk) begin
		if (reset)
			out_bundle <= BUBBLE;
		else if (!freeze)
			out_bundle <= advance ? in_bundle : BUBBLE; // else hold
	end

	a_bubble_empty: assert property (@(posedge clk) disable iff (reset)
		(out_bundle.dec.alu_op == OP_NONE) |->
			(out_bundle.mask == '0 && !out_bundle.dec.wb));

	a_width: assert property (@(posedge clk)
		$bits(out_bundle.mask) == NUM_THREADS);

endmodule

`default_nettype wire

/* src/issue_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

module issue_ctrl #(
	parameter int RESULT_CREDITS = simt_pkg::RESULT_CREDITS
) (
	input  logic                            clk,
	input  logic                            reset,
	input  logic                            instr_valid,
	input  logic                            credit_return,
	input  logic                            result_fire,
	input  simt_pkg::decoded_t              dec,
	input  simt_pkg::decoded_t              held,
	input  logic [simt_pkg::NUM_THREADS-1:0] held_mask,
	output logic                            hazard_stall,
	output logic                            freeze,
	output logic                            instr_ready,
	output logic                            credit_ok
);
	import simt_pkg::*;

	localparam int CW = $clog2(RESULT_CREDITS + 1);

	logic [CW-1:0] credits;
	logic          held_busy;
	logic          held_writes;
	logic          src_hit;

	assign held_busy   = held.wb && (held_mask != '0);
	assign held_writes = held_busy && (held.rd != '0);
	assign src_hit     = (dec.rs1 == held.rd) || (dec.rs2 == held.rd);

	assign hazard_stall = instr_valid && held_writes && src_hit;

	// a result leaving this cycle already owns one credit
	assign credit_ok   = result_fire ? (credits > CW'(1)) : (credits != '0);
	assign freeze      = held_busy && !credit_ok;
	assign instr_ready = !hazard_stall && !freeze;

	always_ff @(posedge clk) begin
		if (reset)
			credits <= CW'(RESULT_CREDITS);
		else
			credits <= credits - CW'(result_fire) + CW'(credit_return);
	end

	a_credit_max: assert property (@(posedge clk) disable iff (reset)
		credits <= CW'(RESULT_CREDITS));

	a_fire_credit: assert property (@(posedge clk) disable iff (reset)
		result_fire |-> (credits != '0));

endmodule

`default_nettype wire

/* src/simt_alu.sv */
`timescale 1ns/1ps
`default_nettype none

module simt_alu #(
	parameter int NUM_THREADS = simt_pkg::NUM_THREADS
) (
	input  logic                              clk,
	input  logic                              reset,
	input  logic                              credit_ok,
	input  simt_pkg::de_bundle_t              bundle,
	output logic [NUM_THREADS-1:0]            wr_en,
	output simt_pkg::reg_idx_t                wr_idx,
	output simt_pkg::word_t [NUM_THREADS-1:0] wr_data,
	output logic                              result_valid,
	output simt_pkg::result_t                 result,
	output logic                              result_fire
);
	import simt_pkg::*;

	word_t [NUM_THREADS-1:0] op_b;
	word_t [NUM_THREADS-1:0] alu_out;
	logic                    fire;

	always_comb begin
		for (int t = 0; t < NUM_THREADS; t++) begin
			op_b[t] = bundle.dec.use_imm ? bundle.dec.imm : bundle.b[t];
			unique case (bundle.dec.alu_op)
				OP_ADD:  alu_out[t] = bundle.a[t] + op_b[t];
				OP_SUB:  alu_out[t] = bundle.a[t] - op_b[t];
				OP_AND:  alu_out[t] = bundle.a[t] & op_b[t];
				OP_OR:   alu_out[t] = bundle.a[t] | op_b[t];
				OP_XOR:  alu_out[t] = bundle.a[t] ^ op_b[t];
				OP_SLL:  alu_out[t] = bundle.a[t] << op_b[t][4:0];
				OP_SRL:  alu_out[t] = bundle.a[t] >> op_b[t][4:0];
				OP_SLT:  alu_out[t] = word_t'($signed(bundle.a[t]) < $signed(op_b[t]));
				OP_LUI:  alu_out[t] = bundle.dec.imm;
				default: alu_out[t] = '0;
			endcase
		end
	end

	assign fire = bundle.dec.wb && (bundle.mask != '0) && credit_ok;

	always_ff @(posedge clk) begin
		if (reset) begin
			result_valid <= 1'b0;
			wr_en        <= '0;
		end else begin
			result_valid <= fire; // one-cycle pulse
			wr_en        <= fire ? bundle.mask : '0;
		end
	end

	always_ff @(posedge clk) begin
		if (fire) begin
			result.rd   <= bundle.dec.rd;
			result.data <= alu_out;
			result.mask <= bundle.mask;
		end
	end

	assign wr_idx      = result.rd;
	assign wr_data     = result.data;
	assign result_fire = result_valid;

endmodule

`default_nettype wire

/* src/simt_exec_slice.sv */
`timescale 1ns/1ps
`default_nettype none

module simt_exec_slice #(
	parameter int NUM_THREADS    = simt_pkg::NUM_THREADS,
	parameter int RESULT_CREDITS = simt_pkg::RESULT_CREDITS
) (
	input  logic                   clk,
	input  logic                   reset,
	input  logic                   instr_valid,
	input  simt_pkg::word_t        instr,
	input  logic [NUM_THREADS-1:0] instr_mask,
	input  logic                   credit_return,
	output logic                   instr_ready,
	output logic                   result_valid,
	output simt_pkg::result_t      result
);
	import simt_pkg::*;

	decoded_t                dec;
	word_t [NUM_THREADS-1:0] rd_a;
	word_t [NUM_THREADS-1:0] rd_b;
	de_bundle_t              in_bundle;
	de_bundle_t              held;
	logic                    hazard_stall;
	logic                    freeze;
	logic                    credit_ok;
	logic                    result_fire;
	logic [NUM_THREADS-1:0]  wr_en;
	reg_idx_t                wr_idx;
	word_t [NUM_THREADS-1:0] wr_data;

	assign in_bundle = '{dec: dec, a: rd_a, b: rd_b, mask: instr_mask};

	inst_decoder inst_decoder_inst (
		.instr   (instr),
		.decoded (dec)
	);

	thread_regfile #(.NUM_THREADS(NUM_THREADS)) thread_regfile_inst (
		.clk     (clk),
		.reset   (reset),
		.rs1     (dec.rs1),
		.rs2     (dec.rs2),
		.rd_a    (rd_a),
		.rd_b    (rd_b),
		.wr_en   (wr_en),
		.wr_idx  (wr_idx),
		.wr_data (wr_data)
	);

	d_e_reg #(.NUM_THREADS(NUM_THREADS)) d_e_reg_inst (
		.clk        (clk),
		.reset      (reset),
		.stall      (hazard_stall),
		.freeze     (freeze),
		.load       (instr_valid),
		.in_bundle  (in_bundle),
		.out_bundle (held)
	);

	issue_ctrl #(.RESULT_CREDITS(RESULT_CREDITS)) issue_ctrl_inst (
		.clk           (clk),
		.reset         (reset),
		.instr_valid   (instr_valid),
		.credit_return (credit_return),
		.result_fire   (result_fire),
		.dec           (dec),
		.held          (held.dec),
		.held_mask     (held.mask),
		.hazard_stall  (hazard_stall),
		.freeze        (freeze),
		.instr_ready   (instr_ready),
		.credit_ok     (credit_ok)
	);

	simt_alu #(.NUM_THREADS(NUM_THREADS)) simt_alu_inst (
		.clk          (clk),
		.reset        (reset),
		.credit_ok    (credit_ok),
		.bundle       (held),
		.wr_en        (wr_en),
		.wr_idx       (wr_idx),
		.wr_data      (wr_data),
		.result_valid (result_valid),
		.result       (result),
		.result_fire  (result_fire)
	);

endmodule

`default_nettype wire

/* test/clock_gen.sv */
`timescale 1ns/1ps
`default_nettype none

module clock_gen #(
	parameter int PERIOD_NS = 40
) (
	output logic clk
);
	initial clk = 1'b0;

	always #(PERIOD_NS / 2) clk = ~clk;

endmodule

`default_nettype wire

/* test/tb_simt_exec_slice.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_simt_exec_slice;
	import simt_pkg::*;

	localparam int NT            = NUM_THREADS;
	localparam int CREDITS       = RESULT_CREDITS;
	localparam int N_RANDOM      = 150;
	localparam int N_PAIRS       = 20;
	localparam int N_HOLD        = 10;
	localparam int HOLD_CYCLES   = 40;
	localparam int SETTLE_CYCLES = 40;
	localparam int N_INSTR       = 11 + N_RANDOM + 2 * N_PAIRS + 15 + N_HOLD + 16;
	localparam int CYCLE_LIMIT   = 10 * N_INSTR + HOLD_CYCLES + SETTLE_CYCLES + 500;

	typedef struct packed {
		logic          idle; // one cycle with instr_valid low
		logic          dep;  // must wait exactly one cycle
		logic [NT-1:0] mask;
		word_t         word;
	} stim_t;

	logic          clk;
	logic          reset = 1'b1;
	logic          instr_valid = 1'b0;
	word_t         instr = '0;
	logic [NT-1:0] instr_mask = '0;
	logic          credit_return = 1'b0;
	logic          instr_ready;
	logic          result_valid;
	result_t       result;

	stim_t   stim_q[$];
	result_t exp_q[$];
	word_t   mregs[NT][32]; // reference register file
	int      delay_tab[256];
	stim_t   cur;
	logic    started = 1'b0;
	logic    offering = 1'b0;
	logic    hold_credits = 1'b0;
	int      wait_cycles = 0;
	int      owed = 0; // results not yet credited back
	int      credit_wait = 0;
	int      delay_idx = 0;
	int      max_delay = 3;
	int      results_seen = 0;
	int      cycle_count = 0;
	int      value_errors = 0;
	int      other_errors = 0;

	clock_gen #(.PERIOD_NS(40)) clock_gen_inst (.clk(clk));

	simt_exec_slice #(
		.NUM_THREADS    (NT),
		.RESULT_CREDITS (CREDITS)
	) simt_exec_slice_inst (
		.clk           (clk),
		.reset         (reset),
		.instr_valid   (instr_valid),
		.instr         (instr),
		.instr_mask    (instr_mask),
		.credit_return (credit_return),
		.instr_ready   (instr_ready),
		.result_valid  (result_valid),
		.result        (result)
	);

	task automatic check_value(input string name, input word_t got, input word_t want);
		if (got !== want) begin
			value_errors++;
			$display("error at %0t: %s is %h, expected %h", $time, name, got, want);
		end
	endtask

	function automatic word_t encode_r(input logic [6:0] f7, input logic [4:0] rs2,
			input logic [4:0] rs1, input logic [2:0] f3, input logic [4:0] rd);
		return {f7, rs2, rs1, f3, rd, 7'b0110011};
	endfunction

	function automatic word_t encode_i(input logic [11:0] imm, input logic [4:0] rs1,
			input logic [2:0] f3, input logic [4:0] rd);
		return {imm, rs1, f3, rd, 7'b0010011};
	endfunction

	function automatic word_t encode_u(input logic [19:0] imm, input logic [4:0] rd);
		return {imm, rd, 7'b0110111};
	endfunction

	function automatic alu_op_e funct3_op(input logic [2:0] f3);
		case (f3)
			3'd0: return OP_ADD;
			3'd1: return OP_SLL;
			3'd2: return OP_SLT;
			3'd4: return OP_XOR;
			3'd5: return OP_SRL;
			3'd6: return OP_OR;
			3'd7: return OP_AND;
			default: return OP_NONE; // sltu
		endcase
	endfunction

	function automatic word_t alu_model(input alu_op_e op, input word_t a, input word_t b);
		case (op)
			OP_ADD: return a + b;
			OP_SUB: return a - b;
			OP_AND: return a & b;
			OP_OR:  return a | b;
			OP_XOR: return a ^ b;
			OP_SLL: return a << b[4:0];
			OP_SRL: return a >> b[4:0];
			OP_SLT: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
			OP_LUI: return b;
			default: return '0;
		endcase
	endfunction

	// RV32I reference for the accepted instruction, in program order
	task automatic model_accept(input word_t w, input logic [NT-1:0] m);
		alu_op_e op;
		word_t   imm;
		word_t   b;
		result_t e;
		op  = OP_NONE;
		imm = (w[6:0] == 7'b0110111) ? {w[31:12], 12'b0} : {{20{w[31]}}, w[31:20]};
		if (w[6:0] == 7'b0110011) begin
			if (w[31:25] == 7'h20 && w[14:12] == 3'd0)
				op = OP_SUB;
			else if (w[31:25] == 7'h00)
				op = funct3_op(w[14:12]);
		end else if (w[6:0] == 7'b0010011) begin
			op = funct3_op(w[14:12]);
			if ((w[14:12] == 3'd1 || w[14:12] == 3'd5) && w[31:25] != 7'h00)
				op = OP_NONE; // srai
		end else if (w[6:0] == 7'b0110111) begin
			op = OP_LUI;
		end
		if (op != OP_NONE && m != '0) begin
			e.rd   = w[11:7];
			e.mask = m;
			for (int t = 0; t < NT; t++) begin
				b = (w[6:0] == 7'b0110011) ? mregs[t][w[24:20]] : imm;
				e.data[t] = alu_model(op, mregs[t][w[19:15]], b);
			end
			for (int t = 0; t < NT; t++) begin
				if (m[t] && w[11:7] != 5'd0)
					mregs[t][w[11:7]] = e.data[t];
			end
			exp_q.push_back(e);
		end
	endtask

	function automatic word_t random_alu_instr(input bit allow_lui);
		int unsigned k;
		logic [4:0]  rd;
		logic [4:0]  rs1;
		logic [4:0]  rs2;
		logic [11:0] imm;
		k   = allow_lui ? $urandom_range(16, 0) : $urandom_range(14, 0);
		rd  = 5'($urandom_range(7, 0));
		rs1 = 5'($urandom_range(7, 0));
		rs2 = 5'($urandom_range(7, 0));
		imm = 12'($urandom);
		if (k == 0)
			return encode_r(7'h20, rs2, rs1, 3'd0, rd);
		else if (k < 8)
			return encode_r(7'h00, rs2, rs1, (k == 3) ? 3'd0 : 3'(k), rd); // add takes the sltu slot
		else if (k < 13)
			return encode_i(imm, rs1,
				(k == 8) ? 3'd0 : (k == 12) ? 3'd7 : 3'(2 * (k - 8)), rd);
		else if (k < 15)
			return encode_i({7'h00, imm[4:0]}, rs1, (k == 13) ? 3'd1 : 3'd5, rd);
		return encode_u(20'($urandom), rd);
	endfunction

	function automatic word_t random_bad_instr();
		logic [4:0]  rd;
		logic [11:0] imm;
		rd  = 5'($urandom_range(7, 1));
		imm = 12'($urandom);
		case ($urandom_range(4, 0))
			0: return encode_r(7'h20, 5'd2, 5'd1, 3'd5, rd);   // sra
			1: return encode_r(7'h00, 5'd2, 5'd1, 3'd3, rd);   // sltu
			2: return encode_r(7'h01, 5'd2, 5'd1, 3'd0, rd);   // mul
			3: return {imm, 5'd1, 3'd2, rd, 7'b0000011};       // lw
			default: return encode_i(imm, 5'd1, 3'd3, rd);     // sltiu
		endcase
	endfunction

	function automatic logic [NT-1:0] random_mask(input bit nonzero);
		logic [NT-1:0] m;
		m = NT'($urandom);
		if (nonzero && m == '0)
			m = '1;
		return m;
	endfunction

	task automatic queue_instr(input word_t w, input logic [NT-1:0] m, input logic dep);
		stim_q.push_back('{idle: 1'b0, dep: dep, mask: m, word: w});
	endtask

	task automatic queue_readback();
		for (int r = 0; r < 8; r++)
			queue_instr(encode_i(12'd0, 5'(r), 3'd0, 5'd0), '1, 1'b0); // x0 as sink
	endtask

	task automatic drain();
		while (stim_q.size() != 0 || offering || exp_q.size() != 0 || owed != 0)
			@(negedge clk);
		repeat (4) @(negedge clk);
	endtask

	always @(negedge clk) begin
		if (started) begin
			if (!offering && stim_q.size() != 0) begin
				cur = stim_q.pop_front();
				offering = !cur.idle;
				wait_cycles = 0;
			end
			instr_valid <= offering;
			instr       <= cur.word;
			instr_mask  <= cur.mask;
			#1; // inputs settled, state fixed until the rising edge
			if (offering && instr_ready) begin
				model_accept(cur.word, cur.mask);
				if (cur.dep)
					check_value("dependent instr wait cycles", word_t'(wait_cycles), 32'd1);
				offering = 1'b0;
			end else if (offering) begin
				wait_cycles++;
			end
		end
	end

	always @(negedge clk) begin
		credit_return <= 1'b0;
		if (started) begin
			if (result_valid)
				owed++;
			if (credit_wait > max_delay)
				credit_wait = max_delay;
			if (owed != 0 && !hold_credits) begin
				if (credit_wait == 0) begin
					credit_return <= 1'b1;
					owed--;
					credit_wait = delay_tab[delay_idx] % (max_delay + 1);
					delay_idx   = (delay_idx + 1) % 256;
				end else begin
					credit_wait--;
				end
			end
		end
	end

	always @(negedge clk) begin
		result_t e;
		if (started && result_valid) begin
			results_seen++;
			if (exp_q.size() == 0) begin
				other_errors++;
				$display("a result arrived at %0t with no instruction expecting one", $time);
			end else begin
				e = exp_q.pop_front();
				check_value("result.rd", word_t'(result.rd), word_t'(e.rd));
				check_value("result.mask", word_t'(result.mask), word_t'(e.mask));
				for (int t = 0; t < NT; t++) begin
					if (e.mask[t])
						check_value($sformatf("result.data[%0d]", t), result.data[t], e.data[t]);
				end
			end
		end
	end

	always @(posedge clk) begin
		cycle_count++;
		if (cycle_count > CYCLE_LIMIT) begin
			$display("timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
			$display("Verification failed");
			$finish;
		end
	end

	initial begin
		word_t w;
		word_t dep;
		int    base;
		void'($urandom(26314));
		for (int i = 0; i < 256; i++)
			delay_tab[i] = $urandom_range(3, 0);
		for (int t = 0; t < NT; t++)
			for (int r = 0; r < 32; r++)
				mregs[t][r] = '0;
		repeat (2) @(posedge clk);
		@(negedge clk);
		reset = 1'b0;
		#1;
		check_value("result_valid", word_t'(result_valid), 32'd0);
		check_value("instr_ready", word_t'(instr_ready), 32'd1);
		started = 1'b1;

		for (int r = 1; r < 8; r++)
			queue_instr(encode_i(12'($urandom), 5'd0, 3'd0, 5'(r)), '1, 1'b0);
		for (int i = 0; i < 4; i++)
			queue_instr(encode_u(20'($urandom), 5'($urandom_range(7, 1))), random_mask(1), 1'b0);
		drain();

		for (int i = 0; i < N_RANDOM; i++) begin
			if ($urandom_range(7, 0) == 0)
				stim_q.push_back('{idle: 1'b1, dep: 1'b0, mask: '0, word: '0});
			if ($urandom_range(9, 0) == 0)
				queue_instr(random_bad_instr(), random_mask(0), 1'b0);
			else
				queue_instr(random_alu_instr(1), random_mask(0), 1'b0);
		end
		drain();

		max_delay = 0; // no freeze, so the stall alone sets the wait
		for (int i = 0; i < N_PAIRS; i++) begin
			w = random_alu_instr(1);
			w[11:7] = 5'($urandom_range(7, 1));
			queue_instr(w, random_mask(1), 1'b0);
			dep = random_alu_instr(0);
			dep[19:15] = w[11:7];
			queue_instr(dep, random_mask(0), 1'b1);
		end
		drain();
		max_delay = 3;

		for (int r = 1; r < 8; r++)
			queue_instr(encode_i(12'($urandom), 5'(r), 3'd0, 5'(r)),
				NT'(1 << $urandom_range(NT - 1, 0)), 1'b0);
		queue_readback();
		drain();

		hold_credits = 1'b1;
		base = results_seen;
		for (int i = 0; i < N_HOLD; i++)
			queue_instr(random_alu_instr(1), '1, 1'b0);
		repeat (HOLD_CYCLES) @(negedge clk);
		if (results_seen - base > CREDITS) begin
			other_errors++;
			$display("%0d results appeared with only %0d credits granted",
				results_seen - base, CREDITS);
		end
		hold_credits = 1'b0;
		drain();

		for (int i = 0; i < 8; i++)
			queue_instr(random_bad_instr(), random_mask(1), 1'b0);
		queue_readback();
		while (stim_q.size() != 0 || offering)
			@(negedge clk);
		repeat (SETTLE_CYCLES) @(negedge clk);
		if (exp_q.size() != 0) begin
			other_errors++;
			$display("%0d expected results never arrived", exp_q.size());
		end
		$display("checks done: %0d value errors, %0d other errors", value_errors, other_errors);
		if (value_errors + other_errors == 0)
			$display("Verification passed");
		else
			$display("Verification failed");
		$finish;
	end

endmodule

`default_nettype wire

/* filelist.f */
src/simt_pkg.sv
src/inst_decoder.sv
src/thread_regfile.sv
src/d_e_reg.sv
src/issue_ctrl.sv
src/simt_alu.sv
src/simt_exec_slice.sv
test/clock_gen.sv
test/tb_simt_exec_slice.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_simt_exec_slice
FILELIST  ?= filelist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing --assert
PASS_MSG  ?= Verification passed

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "$(PASS_MSG)" $(LOG); then \
		echo "sim: PASS"; \
	else \
		echo "sim: FAIL"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
